/* src/strand_pkg.sv */
/*
 * Strand control definitions
 * Strand indices and the kind codes carried on the rollback/suspend/resume
 * event bus of the strand select stage.
 */
package strand_pkg;

	// Enough bits to name any of up to four strands
	localparam int STRAND_ID_W = 2;

	typedef logic [STRAND_ID_W-1:0] strand_id_t;

	// Event bus kind field
	typedef logic [1:0] event_kind_t;

	// Code zero is left unused so an idle bus never decodes as an event
	localparam event_kind_t EV_ROLLBACK = 2'd1;
	localparam event_kind_t EV_SUSPEND  = 2'd2;
	localparam event_kind_t EV_RESUME   = 2'd3;

endpackage

/* src/isa_pkg.sv */
/*
 * Instruction format definitions
 * Instruction and program counter words, the class field that marks
 * long-latency operations, and the NOP word.
 */
package isa_pkg;

	localparam int INSTR_W = 32;
	localparam int PC_W    = 32;

	typedef logic [INSTR_W-1:0] instr_t;
	typedef logic [PC_W-1:0]    pc_t;

	// Sequential instructions are one word apart
	localparam pc_t PC_STEP = 32'd4;

	// The class field sits in the top three bits of every instruction
	localparam int CLASS_MSB = 31;
	localparam int CLASS_LSB = 29;

	typedef logic [CLASS_MSB-CLASS_LSB:0] class_t;

	// Multiply and other operations that take the long execute path
	localparam class_t CLASS_LONG = 3'b110;

	localparam instr_t NOP_INSTR = '0;

	function automatic logic is_long_latency(instr_t instr);
		return instr[CLASS_MSB:CLASS_LSB] == CLASS_LONG;
	endfunction

endpackage

/* src/strand_event_decode.sv */
/*
 * Strand event decoder
 * Registers the encoded event bus and the strand enable mask, and turns
 * each event into a one-cycle pulse on the named strand.
 */
`timescale 1ns/1ps

module strand_event_decode #(
	parameter int NUM_STRANDS = 4
) (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  logic                     event_valid_i,
	input  strand_pkg::event_kind_t  event_kind_i,
	input  strand_pkg::strand_id_t   event_strand_i,
	input  isa_pkg::pc_t             event_pc_i,
	input  logic [NUM_STRANDS-1:0]   strand_enable_i,
	output logic [NUM_STRANDS-1:0]   rollback_o,
	output logic [NUM_STRANDS-1:0]   suspend_o,
	output logic [NUM_STRANDS-1:0]   resume_o,
	output isa_pkg::pc_t             rollback_pc_o,
	output logic [NUM_STRANDS-1:0]   enable_o
);
	import strand_pkg::*;

	logic [NUM_STRANDS-1:0] target;

	// One-hot select of the strand the event names, zero when idle
	assign target = NUM_STRANDS'(event_valid_i) << event_strand_i;

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			rollback_o <= '0;
			suspend_o  <= '0;
			resume_o   <= '0;
			enable_o   <= '0;
		end
		else
		begin
			rollback_o <= (event_kind_i == EV_ROLLBACK) ? target : '0;
			suspend_o  <= (event_kind_i == EV_SUSPEND) ? target : '0;
			resume_o   <= (event_kind_i == EV_RESUME) ? target : '0;
			enable_o   <= strand_enable_i;
		end
	end

	// Only one rollback target is needed since at most one event arrives per cycle
	always_ff @(posedge clk)
	begin
		if (event_valid_i && event_kind_i == EV_ROLLBACK)
			rollback_pc_o <= event_pc_i;
	end

	a_strand_in_range: assert property (@(posedge clk) disable iff (!rst_n_i)
		event_valid_i |-> int'(event_strand_i) < NUM_STRANDS);

endmodule

/* src/strand_fsm.sv */
/*
 * Strand state machine
 * Fetches one instruction at a time over a four-phase req/ack port, holds
 * it until the issue arbiter grants this strand, and handles suspend,
 * resume and rollback.
 */
`timescale 1ns/1ps

module strand_fsm #(
	parameter isa_pkg::pc_t RESET_PC = '0
) (
	input  logic            clk,
	input  logic            rst_n_i,
	input  logic            enable_i,
	input  logic            rollback_i,
	input  isa_pkg::pc_t    rollback_pc_i,
	input  logic            suspend_i,
	input  logic            resume_i,
	input  logic            grant_i,
	output logic            fetch_req_o,
	output isa_pkg::pc_t    fetch_pc_o,
	input  logic            fetch_ack_i,
	input  isa_pkg::instr_t fetch_instr_i,
	output logic            issue_req_o,
	output isa_pkg::instr_t instr_o,
	output isa_pkg::pc_t    pc_o
);
	import isa_pkg::*;

	typedef enum logic [1:0] {
		FETCH,
		ACK_RELEASE,
		READY,
		SUSPENDED
	} state_t;

	state_t state_q;
	logic   req_q;
	pc_t    pc_q;
	pc_t    redirect_pc_q;
	instr_t instr_q;
	logic   suspended_q;
	logic   discard_q;
	logic   susp_next;
	logic   fetch_done;

	// A resume in the same cycle as a suspend wins
	assign susp_next  = (suspended_q | suspend_i) & ~resume_i;
	assign fetch_done = (state_q == FETCH) && req_q && fetch_ack_i;

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			state_q     <= FETCH;
			req_q       <= 1'b0;
			pc_q        <= RESET_PC;
			suspended_q <= 1'b0;
			discard_q   <= 1'b0;
		end
		else
		begin
			suspended_q <= susp_next;
			case (state_q)
				FETCH:
				begin
					if (fetch_done)
					begin
						req_q <= 1'b0;
						if (discard_q || rollback_i)
						begin
							// Word belongs to the abandoned path, so fetch again
							discard_q <= 1'b0;
							pc_q      <= rollback_i ? rollback_pc_i : redirect_pc_q;
						end
						else
							state_q <= ACK_RELEASE;
					end
					else if (req_q)
					begin
						// The PC must stay stable while req is high
						if (rollback_i)
							discard_q <= 1'b1;
					end
					else
					begin
						if (rollback_i)
							pc_q <= rollback_pc_i;
						if (enable_i && !fetch_ack_i)
							req_q <= 1'b1;
					end
				end
				ACK_RELEASE:
				begin
					if (rollback_i)
					begin
						pc_q    <= rollback_pc_i;
						state_q <= FETCH;
					end
					else if (!fetch_ack_i)
						state_q <= susp_next ? SUSPENDED : READY;
				end
				READY:
				begin
					if (grant_i)
					begin
						// Ack is already low here, so the next fetch can start at once
						req_q   <= 1'b1;
						pc_q    <= rollback_i ? rollback_pc_i : pc_q + PC_STEP;
						state_q <= FETCH;
					end
					else if (rollback_i)
					begin
						pc_q    <= rollback_pc_i;
						state_q <= FETCH;
					end
					else if (susp_next)
						state_q <= SUSPENDED;
				end
				SUSPENDED:
				begin
					if (rollback_i)
					begin
						pc_q    <= rollback_pc_i;
						state_q <= FETCH;
					end
					else if (!susp_next)
						state_q <= READY;
				end
				default:
					state_q <= FETCH;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (fetch_done)
			instr_q <= fetch_instr_i;
		if (rollback_i)
			redirect_pc_q <= rollback_pc_i;
	end

	assign fetch_req_o = req_q;
	assign fetch_pc_o  = pc_q;
	assign issue_req_o = (state_q == READY) && enable_i;
	assign instr_o     = instr_q;
	assign pc_o        = pc_q;

	a_grant_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
		grant_i |-> issue_req_o);

endmodule

/* src/execute_hazard_detect.sv */
/*
 * Writeback hazard detector
 * Remembers recent long-latency issues and flags strands whose held
 * single-cycle instruction would write back in the same cycle as one.
 */
`timescale 1ns/1ps

module execute_hazard_detect #(
	parameter int NUM_STRANDS = 4,
	parameter int LONG_STAGES = 4
) (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  isa_pkg::instr_t        instr_i [NUM_STRANDS],
	input  logic [NUM_STRANDS-1:0] grant_i,
	output logic [NUM_STRANDS-1:0] hazard_o
);
	import isa_pkg::*;

	localparam int HIST_W = LONG_STAGES - 1;

	logic [NUM_STRANDS-1:0] long_vec;
	logic [HIST_W-1:0]      hist_q;
	logic                   long_issue;

	always_comb
	begin
		for (int s = 0; s < NUM_STRANDS; s++)
			long_vec[s] = is_long_latency(instr_i[s]);
	end

	assign long_issue = |(grant_i & long_vec);

	// Bit k is set when a long-latency instruction left the issue register k cycles ago
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
			hist_q <= '0;
		else
			hist_q <= (hist_q << 1) | HIST_W'(long_issue);
	end

	// A single-cycle instruction granted now would land on the same writeback slot
	assign hazard_o = {NUM_STRANDS{hist_q[HIST_W-1]}} & ~long_vec;

	a_no_wb_collision: assert property (@(posedge clk) disable iff (!rst_n_i)
		hist_q[HIST_W-1] |-> (grant_i & ~long_vec) == '0);

endmodule

/* src/issue_select.sv */
/*
 * Issue selector
 * Round-robin arbiter over strands that request issue and carry no hazard,
 * followed by the registered mux that drives the issue outputs.
 */
`timescale 1ns/1ps

module issue_select #(
	parameter int NUM_STRANDS = 4
) (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic [NUM_STRANDS-1:0] issue_req_i,
	input  logic [NUM_STRANDS-1:0] hazard_i,
	input  isa_pkg::instr_t        instr_i [NUM_STRANDS],
	input  isa_pkg::pc_t           pc_i [NUM_STRANDS],
	output logic [NUM_STRANDS-1:0] grant_o,
	output logic                   issue_valid_o,
	output isa_pkg::instr_t        issue_instr_o,
	output isa_pkg::pc_t           issue_pc_o,
	output strand_pkg::strand_id_t issue_strand_o
);
	import strand_pkg::*;
	import isa_pkg::*;

	logic [NUM_STRANDS-1:0] eligible;
	strand_id_t             last_q;
	strand_id_t             win;
	logic                   found;

	assign eligible = issue_req_i & ~hazard_i;

	// Search starts just after the strand granted last, so every strand gets a turn
	always_comb
	begin
		int idx;
		grant_o = '0;
		win     = '0;
		found   = 1'b0;
		for (int off = 1; off <= NUM_STRANDS; off++)
		begin
			idx = (int'(last_q) + off) % NUM_STRANDS;
			if (!found && eligible[idx])
			begin
				grant_o[idx] = 1'b1;
				win          = strand_id_t'(idx);
				found        = 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			last_q         <= strand_id_t'(NUM_STRANDS - 1);
			issue_valid_o  <= 1'b0;
			issue_instr_o  <= NOP_INSTR;
			issue_pc_o     <= '0;
			issue_strand_o <= '0;
		end
		else if (found)
		begin
			last_q         <= win;
			issue_valid_o  <= 1'b1;
			issue_instr_o  <= instr_i[win];
			issue_pc_o     <= pc_i[win];
			issue_strand_o <= win;
		end
		else
		begin
			// Nothing eligible this cycle, so a bubble goes down the pipe
			issue_valid_o <= 1'b0;
			issue_instr_o <= NOP_INSTR;
			issue_pc_o    <= '0;
		end
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
		$onehot0(grant_o));

endmodule

/* src/strand_select_stage.sv */
/*
 * Strand select stage
 * Picks one of up to four hardware strands each cycle and issues its next
 * instruction toward decode, scheduling around writeback collisions.
 */
`timescale 1ns/1ps

module strand_select_stage #(
	parameter int NUM_STRANDS = 4,
	parameter int LONG_STAGES = 4
) (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic [NUM_STRANDS-1:0]  strand_enable_i,
	input  logic                    event_valid_i,
	input  strand_pkg::event_kind_t event_kind_i,
	input  strand_pkg::strand_id_t  event_strand_i,
	input  isa_pkg::pc_t            event_pc_i,
	output logic [NUM_STRANDS-1:0]  fetch_req_o,
	output isa_pkg::pc_t            fetch_pc_o [NUM_STRANDS],
	input  logic [NUM_STRANDS-1:0]  fetch_ack_i,
	input  isa_pkg::instr_t         fetch_instr_i [NUM_STRANDS],
	output logic                    issue_valid_o,
	output isa_pkg::instr_t         issue_instr_o,
	output isa_pkg::pc_t            issue_pc_o,
	output strand_pkg::strand_id_t  issue_strand_o
);
	import isa_pkg::*;

	logic [NUM_STRANDS-1:0] rollback;
	logic [NUM_STRANDS-1:0] suspend;
	logic [NUM_STRANDS-1:0] resume;
	logic [NUM_STRANDS-1:0] enable;
	pc_t                    rollback_pc;
	logic [NUM_STRANDS-1:0] issue_req;
	logic [NUM_STRANDS-1:0] hazard_mask;
	logic [NUM_STRANDS-1:0] grant;
	instr_t                 held_instr [NUM_STRANDS];
	pc_t                    held_pc [NUM_STRANDS];

	strand_event_decode #(
		.NUM_STRANDS(NUM_STRANDS)
	) u_event_decode (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.event_valid_i  (event_valid_i),
		.event_kind_i   (event_kind_i),
		.event_strand_i (event_strand_i),
		.event_pc_i     (event_pc_i),
		.strand_enable_i(strand_enable_i),
		.rollback_o     (rollback),
		.suspend_o      (suspend),
		.resume_o       (resume),
		.rollback_pc_o  (rollback_pc),
		.enable_o       (enable)
	);

	for (genvar s = 0; s < NUM_STRANDS; s++)
	begin : g_strand
		// Each strand starts in its own 4 KB region of code
		localparam pc_t STRAND_RESET_PC = 32'h1000 * s;

		strand_fsm #(
			.RESET_PC(STRAND_RESET_PC)
		) u_strand_fsm (
			.clk          (clk),
			.rst_n_i      (rst_n_i),
			.enable_i     (enable[s]),
			.rollback_i   (rollback[s]),
			.rollback_pc_i(rollback_pc),
			.suspend_i    (suspend[s]),
			.resume_i     (resume[s]),
			.grant_i      (grant[s]),
			.fetch_req_o  (fetch_req_o[s]),
			.fetch_pc_o   (fetch_pc_o[s]),
			.fetch_ack_i  (fetch_ack_i[s]),
			.fetch_instr_i(fetch_instr_i[s]),
			.issue_req_o  (issue_req[s]),
			.instr_o      (held_instr[s]),
			.pc_o         (held_pc[s])
		);
	end

	execute_hazard_detect #(
		.NUM_STRANDS(NUM_STRANDS),
		.LONG_STAGES(LONG_STAGES)
	) u_hazard_detect (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.instr_i (held_instr),
		.grant_i (grant),
		.hazard_o(hazard_mask)
	);

	issue_select #(
		.NUM_STRANDS(NUM_STRANDS)
	) u_issue_select (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.issue_req_i   (issue_req),
		.hazard_i      (hazard_mask),
		.instr_i       (held_instr),
		.pc_i          (held_pc),
		.grant_o       (grant),
		.issue_valid_o (issue_valid_o),
		.issue_instr_o (issue_instr_o),
		.issue_pc_o    (issue_pc_o),
		.issue_strand_o(issue_strand_o)
	);

endmodule

/* tests/strand_select_tb.sv */
/*
 * Strand select stage testbench
 * Models the fetch units, applies a table of enable, suspend, resume and
 * rollback events, and checks the issue stream against a per-strand PC model.
 */
`timescale 1ns/1ps

module strand_select_tb;
	import strand_pkg::*;
	import isa_pkg::*;

	localparam int NUM_STRANDS = 4;
	localparam int LONG_STAGES = 4;
	localparam int NUM_ROWS    = 8;
	localparam int END_CYCLE   = 340;
	localparam int NEVER       = 1 << 30;

	logic                   clk;
	logic                   rst_n;
	logic [NUM_STRANDS-1:0] strand_enable;
	logic                   event_valid;
	event_kind_t            event_kind;
	strand_id_t             event_strand;
	pc_t                    event_pc;
	logic [NUM_STRANDS-1:0] fetch_req;
	pc_t                    fetch_pc [NUM_STRANDS];
	logic [NUM_STRANDS-1:0] fetch_ack;
	instr_t                 fetch_instr [NUM_STRANDS];
	logic                   issue_valid;
	instr_t                 issue_instr;
	pc_t                    issue_pc;
	strand_id_t             issue_strand;

	// Stimulus table columns: cycle, event valid, kind, strand, PC, enable mask
	int                     r_cyc [NUM_ROWS];
	logic                   r_valid [NUM_ROWS];
	event_kind_t            r_kind [NUM_ROWS];
	strand_id_t             r_strand [NUM_ROWS];
	pc_t                    r_pc [NUM_ROWS];
	logic [NUM_STRANDS-1:0] r_mask [NUM_ROWS];

	int   cyc;
	int   row;
	logic [31:0] lfsr;
	int   wait_cnt [NUM_STRANDS];
	pc_t  exp_pc [NUM_STRANDS];
	int   issued [NUM_STRANDS];
	int   off_from [NUM_STRANDS];
	int   susp_from [NUM_STRANDS];
	int   rb_cyc [NUM_STRANDS];
	pc_t  rb_pc [NUM_STRANDS];
	int   rb_seq [NUM_STRANDS];
	int   rb_taken [NUM_STRANDS];
	// Bit k is set when a long-latency instruction issued k cycles ago
	logic [LONG_STAGES-1:0] long_hist;
	int   n_checks;
	int   n_errors;
	int   cat_err [1:6];

	strand_select_stage #(
		.NUM_STRANDS(NUM_STRANDS),
		.LONG_STAGES(LONG_STAGES)
	) dut (
		.clk            (clk),
		.rst_n_i        (rst_n),
		.strand_enable_i(strand_enable),
		.event_valid_i  (event_valid),
		.event_kind_i   (event_kind),
		.event_strand_i (event_strand),
		.event_pc_i     (event_pc),
		.fetch_req_o    (fetch_req),
		.fetch_pc_o     (fetch_pc),
		.fetch_ack_i    (fetch_ack),
		.fetch_instr_i  (fetch_instr),
		.issue_valid_o  (issue_valid),
		.issue_instr_o  (issue_instr),
		.issue_pc_o     (issue_pc),
		.issue_strand_o (issue_strand)
	);

	always #20 clk = ~clk;

	// Program memory image: PCs with bit 4 set hold a multiply
	function automatic instr_t fetch_word(pc_t pc);
		return {pc[4] ? CLASS_LONG : 3'b001, pc[28:0]};
	endfunction

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic check(input int cat, input string name, input logic [31:0] got,
		input logic [31:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			$display("[FAIL] %s got %08h expected %08h", name, got, exp);
			n_errors++;
			cat_err[cat]++;
		end
	endtask

	task automatic note_failure(input int cat, input string msg);
		n_checks++;
		n_errors++;
		cat_err[cat]++;
		$display("%s", msg);
	endtask

	task automatic add_row(input int i, input int c, input logic v, input event_kind_t k,
		input strand_id_t s, input pc_t pc, input logic [NUM_STRANDS-1:0] m);
		r_cyc[i]    = c;
		r_valid[i]  = v;
		r_kind[i]   = k;
		r_strand[i] = s;
		r_pc[i]     = pc;
		r_mask[i]   = m;
	endtask

	// Fetch unit model, one responder per strand with a random delay
	always @(posedge clk)
	begin
		logic [1:0] pick;
		if (!rst_n)
		begin
			fetch_ack <= '0;
		end
		else
		begin
			for (int s = 0; s < NUM_STRANDS; s++)
			begin
				if (fetch_ack[s])
				begin
					if (!fetch_req[s])
						fetch_ack[s] <= 1'b0;
				end
				else if (fetch_req[s])
				begin
					if (wait_cnt[s] == 0)
					begin
						lfsr = lfsr_next(lfsr);
						pick[0] = lfsr[0];
						lfsr = lfsr_next(lfsr);
						pick[1] = lfsr[0];
						wait_cnt[s] = 1 + (int'(pick) % 3);
					end
					else if (wait_cnt[s] == 1)
					begin
						fetch_ack[s]   <= 1'b1;
						fetch_instr[s] <= fetch_word(fetch_pc[s]);
						wait_cnt[s] = 0;
					end
					else
						wait_cnt[s] = wait_cnt[s] - 1;
				end
			end
		end
	end

	// Stimulus table player and the bookkeeping of when each event must take hold
	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		event_valid <= 1'b0;
		if (rst_n && row < NUM_ROWS && cyc == r_cyc[row])
		begin
			event_valid   <= r_valid[row];
			event_kind    <= r_kind[row];
			event_strand  <= r_strand[row];
			event_pc      <= r_pc[row];
			strand_enable <= r_mask[row];
			for (int s = 0; s < NUM_STRANDS; s++)
			begin
				if (!r_mask[row][s] && strand_enable[s])
					off_from[s] <= cyc + 3;
				else if (r_mask[row][s])
					off_from[s] <= NEVER;
			end
			if (r_valid[row] && r_kind[row] == EV_ROLLBACK)
			begin
				rb_cyc[r_strand[row]] <= cyc;
				rb_pc[r_strand[row]]  <= r_pc[row];
				rb_seq[r_strand[row]] <= rb_seq[r_strand[row]] + 1;
			end
			if (r_valid[row] && r_kind[row] == EV_SUSPEND)
				susp_from[r_strand[row]] <= cyc + 4;
			if (r_valid[row] && r_kind[row] == EV_RESUME)
				susp_from[r_strand[row]] <= NEVER;
			row <= row + 1;
		end
	end

	// Issue monitor with the reference PC model, sampled away from the rising edge
	always @(negedge clk)
	begin : monitor
		int s;
		int cat;
		if (rst_n)
			long_hist = long_hist << 1;
		if (rst_n && issue_valid)
		begin
			s = int'(issue_strand);
			cat = (issued[s] == 0) ? 1 : 2;
			if (cyc >= off_from[s])
				note_failure(3, $sformatf("Strand %0d issued while disabled", s));
			if (cyc >= susp_from[s])
				note_failure(4, $sformatf("Strand %0d issued while suspended", s));
			// Old-path issues are tolerated just after a rollback
			if (rb_seq[s] != rb_taken[s] && cyc > rb_cyc[s] + 3)
			begin
				exp_pc[s] = rb_pc[s];
				rb_taken[s] = rb_seq[s];
				cat = 5;
			end
			check(cat, "issue_pc_o", issue_pc, exp_pc[s]);
			check(2, "issue_instr_o", issue_instr, fetch_word(exp_pc[s]));
			exp_pc[s] = exp_pc[s] + 32'd4;
			issued[s]++;
			if (issue_instr[CLASS_MSB:CLASS_LSB] == CLASS_LONG)
				long_hist[0] = 1'b1;
			else if (long_hist[LONG_STAGES-1])
				note_failure(6, $sformatf("Single-cycle issue of strand %0d hits writeback", s));
		end
		else if (rst_n)
			check(1, "issue_instr_o", issue_instr, NOP_INSTR);
	end

	initial
	begin
		int guard;
		logic pending;
		clk = 1'b0;
		rst_n = 1'b0;
		strand_enable = '1;
		event_valid = 1'b0;
		event_kind = '0;
		event_strand = '0;
		event_pc = '0;
		fetch_ack = '0;
		lfsr = 32'hc7f7cd97;
		cyc = 0;
		row = 0;
		long_hist = '0;
		n_checks = 0;
		n_errors = 0;
		for (int c = 1; c <= 6; c++)
			cat_err[c] = 0;
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			fetch_instr[s] = '0;
			wait_cnt[s] = 0;
			exp_pc[s] = 32'h1000 * s;
			issued[s] = 0;
			off_from[s] = NEVER;
			susp_from[s] = NEVER;
			rb_cyc[s] = 0;
			rb_pc[s] = '0;
			rb_seq[s] = 0;
			rb_taken[s] = 0;
		end
		add_row(0, 40, 1'b0, EV_ROLLBACK, 2'd0, 32'h0, 4'b1011);
		add_row(1, 90, 1'b0, EV_ROLLBACK, 2'd0, 32'h0, 4'b1111);
		add_row(2, 120, 1'b1, EV_SUSPEND, 2'd1, 32'h0, 4'b1111);
		add_row(3, 170, 1'b1, EV_RESUME, 2'd1, 32'h0, 4'b1111);
		add_row(4, 200, 1'b1, EV_ROLLBACK, 2'd3, 32'h3800, 4'b1111);
		add_row(5, 230, 1'b1, EV_ROLLBACK, 2'd0, 32'h0400, 4'b1111);
		add_row(6, 260, 1'b1, EV_SUSPEND, 2'd2, 32'h0, 4'b1111);
		add_row(7, 300, 1'b1, EV_RESUME, 2'd2, 32'h0, 4'b1111);

		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check(1, "issue_valid_o", {31'd0, issue_valid}, 32'd0);
		check(1, "issue_instr_o", issue_instr, NOP_INSTR);

		guard = 0;
		while (cyc < END_CYCLE && guard < END_CYCLE + 100)
		begin
			@(posedge clk);
			guard++;
		end
		if (cyc < END_CYCLE)
		begin
			$display("Timed out before the stimulus table finished");
			$display("CHECKS FAILED");
			$finish;
		end
		else
		begin
			// Every rollback must eventually be seen at the issue port
			guard = 0;
			pending = 1'b1;
			while (pending && guard < 200)
			begin
				@(posedge clk);
				guard++;
				pending = 1'b0;
				for (int s = 0; s < NUM_STRANDS; s++)
					if (rb_seq[s] != rb_taken[s])
						pending = 1'b1;
			end
			if (pending)
				note_failure(5, "A rollback target was never issued");
			for (int s = 0; s < NUM_STRANDS; s++)
				if (issued[s] == 0)
					note_failure(1, $sformatf("Strand %0d never issued", s));
			$display("test 1 reset and first issue: %0d errors", cat_err[1]);
			$display("test 2 program order: %0d errors", cat_err[2]);
			$display("test 3 enable mask: %0d errors", cat_err[3]);
			$display("test 4 suspend and resume: %0d errors", cat_err[4]);
			$display("test 5 rollback: %0d errors", cat_err[5]);
			$display("test 6 writeback hazard: %0d errors", cat_err[6]);
			$display("checks %0d, failures %0d", n_checks, n_errors);
			if (n_errors == 0)
				$display("ALL CHECKS PASSED");
			else
				$display("CHECKS FAILED");
			$finish;
		end
	end

endmodule

/* flist.f */
src/strand_pkg.sv
src/isa_pkg.sv
src/strand_event_decode.sv
src/strand_fsm.sv
src/execute_hazard_detect.sv
src/issue_select.sv
src/strand_select_stage.sv
tests/strand_select_tb.sv

/* run.sh */
#!/bin/sh
# Builds the strand select stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f \
	--top-module strand_select_tb -o sim_strand_select
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_strand_select > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
	exit 1
fi
exit 0
